// File: sources.f
+incdir+include
verilog/exe_pkg.sv
verilog/exe_fu_if.sv
verilog/exe_operand_fwd.sv
verilog/exe_alu.sv
verilog/exe_branch.sv
verilog/exe_lsu_addr.sv
verilog/exe_pipe_reg.sv
verilog/execute.sv
testbench/execute_props.sv
testbench/execute_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ns -f sources.f \
   --top-module execute_tb -o execute_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/execute_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
   echo "FAIL"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "FAIL: simulator exited with status $status"
   exit 1
fi
echo "PASS"
exit 0

// File: testbench/execute_tb.sv
// --------------------
// Execute stage testbench
// Random decode traffic against a reference
// model, with a queue as scoreboard
// --------------------
`include "exe_consts.svh"

module execute_tb;
   timeunit 1ns;
   timeprecision 1ns;
   import exe_pkg::*;

   localparam int NUM_CYCLES  = 4000;
   localparam int DRAIN_LIMIT = 50;              // Cycles allowed to empty the queue

   integer     seed;
   logic       clk_in, rst, halt, flush;
   logic       dec_valid, dec_rdy, rd_wr, rs1_rd, rs2_rd;
   ig_type_e   ig_type;
   logic [3:0] op;
   logic [2:0] funct3;
   pc_t        pc, predicted_addr, rld_pc_addr, mem_pc;
   word_t      imm;
   sel_x_e     sel_x;
   sel_y_e     sel_y;
   gpr_addr_t  rd_addr, rs1_addr, rs2_addr, mem_rd_addr;
   word_t [`NUM_GPR-1:0] gpr;
   logic       fwd_mem_valid, fwd_mem_rd_wr, fwd_wb_valid, fwd_wb_rd_wr;
   gpr_addr_t  fwd_mem_rd_addr, fwd_wb_rd_addr;
   word_t      fwd_mem_rd_data, fwd_wb_rd_data;
   logic       rld_pc_flag, mem_valid, mem_rdy, mem_rd_wr, mem_is_ld, mem_is_st;
   word_t      mem_rd_data, mem_ls_addr, mem_st_data;
   ls_size_t   mem_size;
   logic       mem_zero_ext, mem_instr_err;

   exe_mem_t   exp_q[$];                         // Results expected on the MEM side
   logic       pass_reached = 1'b0;
   logic       fail_reported = 1'b0;

   execute uut (.*);

   initial
   begin
      clk_in = 1'b0;
      forever #50 clk_in = ~clk_in;
   end

   // --------------------
   // Error reporting
   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      fail_reported = 1'b1;
      $display("Errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (exp === act)
      else stop_on_error($sformatf("** Error %s: expected %h actual %h", name, exp, act));
   endtask

   // --------------------
   // Random helpers
   function automatic int unsigned rnd(input int unsigned n);
      int unsigned v;
      v = $unsigned($random(seed));
      return v % n;
   endfunction

   function automatic word_t rword();
      return word_t'($random(seed));
   endfunction

   // --------------------
   // Reference model
   function automatic word_t operand(input gpr_addr_t a, input logic en);
      if (en && a != '0 && fwd_mem_valid && fwd_mem_rd_wr && fwd_mem_rd_addr == a)
         return fwd_mem_rd_data;                 // MEM stage is newest
      if (en && a != '0 && fwd_wb_valid && fwd_wb_rd_wr && fwd_wb_rd_addr == a)
         return fwd_wb_rd_data;
      return gpr[a];
   endfunction

   // Signed less-than by flipping the sign bits
   function automatic logic lt_s(input word_t a, input word_t b);
      return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
   endfunction

   function automatic word_t alu_ref(input alu_op_e o, input word_t x, input word_t y);
      logic [4:0] s;
      s = y[4:0];
      case (o)
         ADD:     return x + y;
         SUB:     return x + ~y + 32'd1;
         AND:     return x & y;
         OR:      return x | y;
         XOR:     return x ^ y;
         SLL:     return x << s;
         SRL:     return x >> s;
         SRA:     return (x >> s) | (x[31] ? ~(32'hffff_ffff >> s) : 32'h0);
         SLT:     return {31'd0, lt_s(x, y)};
         SLTU:    return {31'd0, x < y};
         default: return 32'h0;
      endcase
   endfunction

   task automatic predict(output exe_mem_t r, output logic rld, output pc_t rld_addr);
      word_t a, b, x, y;
      pc_t   tgt;
      logic  take;
      a = operand(rs1_addr, rs1_rd);
      b = operand(rs2_addr, rs2_rd);
      r = '0;
      r.pc = pc;
      rld = 1'b0;
      rld_addr = '0;
      case (ig_type)
         IG_ALU:
         begin
            x = (sel_x == X_RS1) ? a : ((sel_x == X_PC) ? pc : 32'h0);
            y = (sel_y == Y_IMM) ? imm : b;
            r.rd_wr   = rd_wr && rd_addr != '0;
            r.rd_addr = rd_addr;
            r.rd_data = alu_ref(alu_op_e'(op), x, y);
         end
         IG_BR:
         begin
            case (funct3)
               3'd0:    take = (a == b);
               3'd1:    take = (a != b);
               3'd4:    take = lt_s(a, b);
               3'd5:    take = !lt_s(a, b);
               3'd6:    take = (a < b);
               default: take = !(a < b);
            endcase
            case (op[1:0])
               2'd1:    tgt = pc + imm;                      // JAL
               2'd2:    tgt = (a + imm) & 32'hffff_fffe;     // JALR
               default: tgt = take ? pc + imm : pc + 32'd4;
            endcase
            if (tgt[1])
               r.instr_err = 1'b1;
            else if (tgt != predicted_addr)
            begin
               rld      = 1'b1;
               rld_addr = tgt;
            end
            else if (op[1:0] != 2'd0)
            begin
               r.rd_wr   = rd_wr && rd_addr != '0;
               r.rd_addr = rd_addr;
               r.rd_data = pc + 32'd4;
            end
         end
         IG_LD, IG_ST:
         begin
            r.ls_addr = a + imm;
            r.size    = (funct3[1:0] == 2'd0) ? 3'd1 : ((funct3[1:0] == 2'd1) ? 3'd2 : 3'd4);
            r.instr_err = (r.size == 3'd2 && r.ls_addr[0]) ||
                          (r.size == 3'd4 && r.ls_addr[1:0] != 2'd0);
            if (ig_type == IG_LD)
            begin
               r.is_ld    = 1'b1;
               r.zero_ext = funct3[2];
               r.rd_wr    = rd_wr && rd_addr != '0;
               r.rd_addr  = rd_addr;
            end
            else
            begin
               r.is_st   = 1'b1;
               r.st_data = b;
            end
         end
         default: r.instr_err = 1'b1;                        // Illegal passes through
      endcase
   endtask

   task automatic compare_result(input exe_mem_t e);
      check_value("mem_pc", e.pc, mem_pc);
      check_value("mem_rd_wr", 32'(e.rd_wr), 32'(mem_rd_wr));
      check_value("mem_rd_addr", 32'(e.rd_addr), 32'(mem_rd_addr));
      check_value("mem_rd_data", e.rd_data, mem_rd_data);
      check_value("mem_is_ld", 32'(e.is_ld), 32'(mem_is_ld));
      check_value("mem_is_st", 32'(e.is_st), 32'(mem_is_st));
      check_value("mem_ls_addr", e.ls_addr, mem_ls_addr);
      check_value("mem_st_data", e.st_data, mem_st_data);
      check_value("mem_size", 32'(e.size), 32'(mem_size));
      check_value("mem_zero_ext", 32'(e.zero_ext), 32'(mem_zero_ext));
      check_value("mem_instr_err", 32'(e.instr_err), 32'(mem_instr_err));
   endtask

   // --------------------
   // Scoreboard sampled mid-cycle where everything is settled
   always @(negedge clk_in)
   begin
      exe_mem_t exp_r;
      logic     exp_rld;
      pc_t      exp_rld_addr;
      logic     out_x;
      if (rst)
         exp_q.delete();                         // Reset empties the stage
      else
      begin
         out_x = mem_valid && mem_rdy;
         check_value("mem_valid", 32'(exp_q.size() != 0), 32'(mem_valid));
         check_value("dec_rdy", 32'(!halt && (exp_q.size() == 0 || out_x)), 32'(dec_rdy));
         if (out_x)
            compare_result(exp_q.pop_front());
         if (dec_valid && dec_rdy)
         begin
            predict(exp_r, exp_rld, exp_rld_addr);
            check_value("rld_pc_flag", 32'(exp_rld), 32'(rld_pc_flag));
            if (exp_rld)
               check_value("rld_pc_addr", exp_rld_addr, rld_pc_addr);
            exp_q.push_back(exp_r);
         end
         else if (!dec_valid)
            check_value("rld_pc_flag idle", 32'h0, 32'(rld_pc_flag));
         if (flush)
            exp_q.delete();                      // Held and incoming results dropped
      end
   end

   // --------------------
   // Stimulus with one new set of inputs per rising edge
   task automatic drive_random();
      ig_type_e             g;
      pc_t                  new_pc;
      word_t                new_imm;
      gpr_addr_t            r1;
      word_t [`NUM_GPR-1:0] g_new;
      int unsigned          k;
      int                   i;
      g       = ig_type_e'(3'(rnd(5)));
      new_pc  = rword() & 32'hffff_fffc;
      new_imm = (g == IG_BR) ? (rword() & 32'hffff_fffe) : rword();
      r1      = 5'(rnd(8));                      // Small range so forwarding hits
      for (i = 0; i < `NUM_GPR; i++)
         g_new[i] = rword();
      k = rnd(6);
      dec_valid <= (rnd(4) != 0);
      ig_type   <= g;
      case (g)
         IG_ALU:  op <= 4'(rnd(10));
         IG_BR:   op <= 4'(rnd(3));
         default: op <= 4'(rnd(16));
      endcase
      funct3    <= (g == IG_BR) ? ((k < 2) ? 3'(k) : 3'(k + 2)) : 3'(rnd(8));
      pc        <= new_pc;
      imm       <= new_imm;
      case (rnd(4))
         0:       predicted_addr <= new_pc + 32'd4;
         1:       predicted_addr <= new_pc + new_imm;
         2:       predicted_addr <= (g_new[r1] + new_imm) & 32'hffff_fffe;
         default: predicted_addr <= rword();
      endcase
      sel_x     <= sel_x_e'(2'(rnd(3)));
      sel_y     <= sel_y_e'(1'(rnd(2)));
      rd_addr   <= 5'(rnd(8));
      rs1_addr  <= r1;
      rs2_addr  <= 5'(rnd(8));
      rd_wr     <= (rnd(4) != 0);
      rs1_rd    <= (rnd(8) != 0);
      rs2_rd    <= (rnd(8) != 0);
      gpr       <= g_new;
      fwd_mem_valid   <= (rnd(2) != 0);
      fwd_mem_rd_wr   <= (rnd(4) != 0);
      fwd_mem_rd_addr <= 5'(rnd(8));
      fwd_mem_rd_data <= rword();
      fwd_wb_valid    <= (rnd(2) != 0);
      fwd_wb_rd_wr    <= (rnd(4) != 0);
      fwd_wb_rd_addr  <= 5'(rnd(8));
      fwd_wb_rd_data  <= rword();
      mem_rdy   <= (rnd(5) < 3);
      halt      <= (rnd(16) == 0);
      flush     <= (rnd(32) == 0);
      rst       <= (rnd(64) == 0);               // Rare reset while a result may be held
   endtask

   initial
   begin
      int cycle;
      int wait_cnt;
      seed = 32'hecd0f120;
      rst = 1'b1;
      halt = 1'b0;
      flush = 1'b0;
      dec_valid = 1'b0;
      ig_type = IG_ALU;
      op = '0;
      funct3 = '0;
      pc = '0;
      predicted_addr = '0;
      imm = '0;
      sel_x = X_RS1;
      sel_y = Y_RS2;
      rd_addr = '0;
      rs1_addr = '0;
      rs2_addr = '0;
      rd_wr = 1'b0;
      rs1_rd = 1'b0;
      rs2_rd = 1'b0;
      gpr = '0;
      fwd_mem_valid = 1'b0;
      fwd_mem_rd_wr = 1'b0;
      fwd_mem_rd_addr = '0;
      fwd_mem_rd_data = '0;
      fwd_wb_valid = 1'b0;
      fwd_wb_rd_wr = 1'b0;
      fwd_wb_rd_addr = '0;
      fwd_wb_rd_data = '0;
      mem_rdy = 1'b0;
      repeat (3) @(posedge clk_in);
      rst <= 1'b0;
      for (cycle = 0; cycle < NUM_CYCLES; cycle++)
      begin
         @(posedge clk_in);
         drive_random();
      end
      // Drain whatever is still held
      @(posedge clk_in);
      rst       <= 1'b0;
      dec_valid <= 1'b0;
      halt      <= 1'b0;
      flush     <= 1'b0;
      mem_rdy   <= 1'b1;
      wait_cnt = 0;
      while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT)
      begin
         @(posedge clk_in);
         wait_cnt++;
      end
      if (exp_q.size() != 0)
         stop_on_error("Timeout: results still expected after the drain period");
      else
      begin
         pass_reached = 1'b1;
         $display("No errors");
         $finish;
      end
   end

   // Catches runs stopped by a bound property
   final
   begin
      if (!pass_reached && !fail_reported)
         $display("Errors found");
   end

endmodule

// File: testbench/execute_props.sv
// --------------------
// Execute stage properties
// Reset, stall and halt checks, bound into
// the execute top level
// --------------------
module execute_props
(
   input logic           clk_in,
   input logic           rst,
   input logic           halt,
   input logic           flush,
   input logic           dec_rdy,
   input logic           mem_valid,
   input logic           mem_rdy,
   input exe_pkg::pc_t   mem_pc,
   input exe_pkg::word_t mem_rd_data,
   input exe_pkg::word_t mem_ls_addr,
   input exe_pkg::word_t mem_st_data
);
   timeunit 1ns;
   timeprecision 1ns;

   // Pipeline register comes out of reset empty
   a_rst_empty: assert property (@(posedge clk_in) rst |=> !mem_valid)
      else $error("mem_valid high in the cycle after reset");

   // Stalled result keeps its payload until MEM takes it or a flush drops it
   a_stall_hold: assert property (@(posedge clk_in) disable iff (rst)
      (mem_valid && !mem_rdy && !flush) |=>
         (mem_valid && $stable(mem_pc) && $stable(mem_rd_data)
          && $stable(mem_ls_addr) && $stable(mem_st_data)))
      else $error("stalled mem result changed or vanished");

   a_halt_rdy: assert property (@(posedge clk_in) halt |-> !dec_rdy)
      else $error("dec_rdy high while halt is high");

endmodule

bind execute execute_props u_props
(
   .clk_in(clk_in), .rst(rst), .halt(halt), .flush(flush), .dec_rdy(dec_rdy),
   .mem_valid(mem_valid), .mem_rdy(mem_rdy), .mem_pc(mem_pc),
   .mem_rd_data(mem_rd_data), .mem_ls_addr(mem_ls_addr), .mem_st_data(mem_st_data)
);

// File: verilog/execute.sv
// --------------------
// RV32 execute stage
// Forwards operands, runs the ALU, branch and
// load/store units, requests PC reloads and
// registers the result toward MEM
// --------------------
`include "exe_consts.svh"

module execute
(
   input  logic                          clk_in,
   input  logic                          rst,
   input  logic                          halt,
   input  logic                          flush,
   // Decode side
   input  logic                          dec_valid,
   output logic                          dec_rdy,
   input  exe_pkg::ig_type_e             ig_type,
   input  logic [3:0]                    op,
   input  logic [2:0]                    funct3,
   input  exe_pkg::pc_t                  pc,
   input  exe_pkg::pc_t                  predicted_addr,
   input  exe_pkg::word_t                imm,
   input  exe_pkg::sel_x_e               sel_x,
   input  exe_pkg::sel_y_e               sel_y,
   input  exe_pkg::gpr_addr_t            rd_addr,
   input  exe_pkg::gpr_addr_t            rs1_addr,
   input  exe_pkg::gpr_addr_t            rs2_addr,
   input  logic                          rd_wr,
   input  logic                          rs1_rd,
   input  logic                          rs2_rd,
   input  exe_pkg::word_t [`NUM_GPR-1:0] gpr,
   // Forwarding
   input  logic                          fwd_mem_valid,
   input  logic                          fwd_mem_rd_wr,
   input  exe_pkg::gpr_addr_t            fwd_mem_rd_addr,
   input  exe_pkg::word_t                fwd_mem_rd_data,
   input  logic                          fwd_wb_valid,
   input  logic                          fwd_wb_rd_wr,
   input  exe_pkg::gpr_addr_t            fwd_wb_rd_addr,
   input  exe_pkg::word_t                fwd_wb_rd_data,
   // Fetch reload
   output logic                          rld_pc_flag,
   output exe_pkg::pc_t                  rld_pc_addr,
   // Memory side
   output logic                          mem_valid,
   input  logic                          mem_rdy,
   output exe_pkg::pc_t                  mem_pc,
   output logic                          mem_rd_wr,
   output exe_pkg::gpr_addr_t            mem_rd_addr,
   output exe_pkg::word_t                mem_rd_data,
   output logic                          mem_is_ld,
   output logic                          mem_is_st,
   output exe_pkg::word_t                mem_ls_addr,
   output exe_pkg::word_t                mem_st_data,
   output exe_pkg::ls_size_t             mem_size,
   output logic                          mem_zero_ext,
   output logic                          mem_instr_err
);
   import exe_pkg::*;

   logic       xfer_in;
   logic       xfer_out;
   logic       pipe_full;
   logic       rd_wr_nz;
   exe_mem_t   exe_dout;
   exe_mem_t   exe_q;
   word_t      rs1_d;
   word_t      rs2_d;
   word_t      alu_rd_data;
   pc_t        br_pc;
   pc_t        link_pc;
   logic       br_mis;
   word_t      ls_addr;
   word_t      st_data;
   ls_size_t   ls_size;
   logic       ls_zero_ext;
   logic       ls_mis;

   // --------------------
   // Handshake, single entry so MEM back-pressure reaches decode
   assign dec_rdy   = !rst & !halt & (!pipe_full | xfer_out);
   assign xfer_in   = dec_valid & dec_rdy;
   assign xfer_out  = mem_valid & mem_rdy;
   assign mem_valid = pipe_full;
   assign rd_wr_nz  = rd_wr & (rd_addr != '0);       // Never write x0

   exe_operand_fwd u_fwd
   (
      .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_rd(rs1_rd), .rs2_rd(rs2_rd), .gpr(gpr),
      .fwd_mem_valid(fwd_mem_valid), .fwd_mem_rd_wr(fwd_mem_rd_wr),
      .fwd_mem_rd_addr(fwd_mem_rd_addr), .fwd_mem_rd_data(fwd_mem_rd_data),
      .fwd_wb_valid(fwd_wb_valid), .fwd_wb_rd_wr(fwd_wb_rd_wr),
      .fwd_wb_rd_addr(fwd_wb_rd_addr), .fwd_wb_rd_data(fwd_wb_rd_data),
      .rs1_data(rs1_d), .rs2_data(rs2_d)
   );

   // Shared operand bus for all units
   exe_fu_if fu_bus();

   assign fu_bus.rs1_data = rs1_d;
   assign fu_bus.rs2_data = rs2_d;
   assign fu_bus.pc       = pc;
   assign fu_bus.imm      = imm;
   assign fu_bus.funct3   = funct3;
   assign fu_bus.op       = op;
   assign fu_bus.sel_x    = sel_x;
   assign fu_bus.sel_y    = sel_y;

   exe_alu      u_alu (.fu_bus(fu_bus), .rd_data(alu_rd_data));
   exe_branch   u_br  (.fu_bus(fu_bus), .br_pc(br_pc), .link_pc(link_pc), .mis(br_mis));
   exe_lsu_addr u_lsu (.fu_bus(fu_bus), .ls_addr(ls_addr), .st_data(st_data),
                       .size(ls_size), .zero_ext(ls_zero_ext), .mis(ls_mis));

   // --------------------
   // Result select and reload request
   always_comb
   begin
      exe_dout    = '0;
      exe_dout.pc = pc;
      rld_pc_flag = 1'b0;
      rld_pc_addr = '0;
      case (ig_type)
         IG_ALU:
         begin
            exe_dout.rd_wr   = rd_wr_nz;
            exe_dout.rd_addr = rd_addr;
            exe_dout.rd_data = alu_rd_data;
         end
         IG_BR:
         begin
            if (br_mis)
               exe_dout.instr_err = 1'b1;            // Trap later, no redirect
            else if (br_pc != predicted_addr)
            begin
               rld_pc_flag = dec_valid;              // Mispredict, refetch
               rld_pc_addr = br_pc;
            end
            else if (br_op_e'(op[1:0]) != B_COND)
            begin
               exe_dout.rd_wr   = rd_wr_nz;          // Link only on the kept path
               exe_dout.rd_addr = rd_addr;
               exe_dout.rd_data = link_pc;
            end
         end
         IG_LD:
         begin
            exe_dout.rd_wr     = rd_wr_nz;           // Data arrives in MEM
            exe_dout.rd_addr   = rd_addr;
            exe_dout.is_ld     = 1'b1;
            exe_dout.ls_addr   = ls_addr;
            exe_dout.size      = ls_size;
            exe_dout.zero_ext  = ls_zero_ext;
            exe_dout.instr_err = ls_mis;
         end
         IG_ST:
         begin
            exe_dout.is_st     = 1'b1;
            exe_dout.ls_addr   = ls_addr;
            exe_dout.st_data   = st_data;
            exe_dout.size      = ls_size;
            exe_dout.instr_err = ls_mis;
         end
         default:                                    // IG_ILL and unused codes
            exe_dout.instr_err = 1'b1;
      endcase
   end

   exe_pipe_reg u_pipe
   (
      .clk_in(clk_in), .rst(rst), .flush(flush),
      .write(xfer_in), .din(exe_dout),
      .read(xfer_out), .full(pipe_full), .dout(exe_q)
   );

   // Unpack toward MEM
   assign mem_pc        = exe_q.pc;
   assign mem_rd_wr     = exe_q.rd_wr;
   assign mem_rd_addr   = exe_q.rd_addr;
   assign mem_rd_data   = exe_q.rd_data;
   assign mem_is_ld     = exe_q.is_ld;
   assign mem_is_st     = exe_q.is_st;
   assign mem_ls_addr   = exe_q.ls_addr;
   assign mem_st_data   = exe_q.st_data;
   assign mem_size      = exe_q.size;
   assign mem_zero_ext  = exe_q.zero_ext;
   assign mem_instr_err = exe_q.instr_err;

endmodule

// File: verilog/exe_pipe_reg.sv
// --------------------
// EXE to MEM pipeline register
// One entry with a full flag; flush drops
// whatever is held
// --------------------
module exe_pipe_reg
(
   input  logic               clk_in,
   input  logic               rst,
   input  logic               flush,
   input  logic               write,
   input  exe_pkg::exe_mem_t  din,
   input  logic               read,
   output logic               full,
   output exe_pkg::exe_mem_t  dout
);

   // Occupancy
   always_ff @(posedge clk_in)
   begin
      if (rst | flush)
         full <= 1'b0;                  // Squash held result
      else if (write)
         full <= 1'b1;                  // Load, possibly while draining
      else if (read)
         full <= 1'b0;
   end

   // Payload
   always_ff @(posedge clk_in)
   begin
      if (write)
         dout <= din;
   end

endmodule

// File: verilog/exe_lsu_addr.sv
// --------------------
// Load/store address unit
// Effective address, access size, sign
// handling and alignment check
// --------------------
`include "exe_consts.svh"

module exe_lsu_addr
(
   exe_fu_if.fu               fu_bus,
   output exe_pkg::word_t     ls_addr,
   output exe_pkg::word_t     st_data,
   output exe_pkg::ls_size_t  size,
   output logic               zero_ext,
   output logic               mis
);

   assign ls_addr  = fu_bus.rs1_data + fu_bus.imm;
   assign st_data  = fu_bus.rs2_data;                 // Byte lanes sorted out in MEM
   assign zero_ext = fu_bus.funct3[2];                // LBU, LHU

   always_comb
   begin
      case (fu_bus.funct3[1:0])
         2'b00:   size = 3'd1;                        // Byte
         2'b01:   size = 3'd2;                        // Halfword
         default: size = 3'd4;                        // Word
      endcase
   end

   // --------------------
   // Alignment by access size
   always_comb
   begin
      case (size)
         3'd2:    mis = |(ls_addr & `HALF_MIS_MASK);
         3'd4:    mis = |(ls_addr & `WORD_MIS_MASK);
         default: mis = 1'b0;                         // Bytes are always aligned
      endcase
   end

endmodule

// File: verilog/exe_branch.sv
// --------------------
// Branch unit
// Compare, target, link address and
// instruction alignment check
// --------------------
module exe_branch
(
   exe_fu_if.fu           fu_bus,
   output exe_pkg::pc_t   br_pc,
   output exe_pkg::pc_t   link_pc,
   output logic           mis
);
   import exe_pkg::*;

   logic   taken;
   pc_t    seq_pc;
   pc_t    rel_pc;
   pc_t    reg_pc;

   assign seq_pc  = fu_bus.pc + 32'd4;                         // Fall through
   assign rel_pc  = fu_bus.pc + fu_bus.imm;                    // Bxx and JAL
   assign reg_pc  = (fu_bus.rs1_data + fu_bus.imm) & ~32'd1;   // JALR clears bit 0
   assign link_pc = seq_pc;

   // Condition from funct3
   always_comb
   begin
      case (fu_bus.funct3)
         3'b000:  taken = (fu_bus.rs1_data == fu_bus.rs2_data);                  // BEQ
         3'b001:  taken = (fu_bus.rs1_data != fu_bus.rs2_data);                  // BNE
         3'b100:  taken = ($signed(fu_bus.rs1_data) < $signed(fu_bus.rs2_data));  // BLT
         3'b101:  taken = ($signed(fu_bus.rs1_data) >= $signed(fu_bus.rs2_data)); // BGE
         3'b110:  taken = (fu_bus.rs1_data < fu_bus.rs2_data);                   // BLTU
         3'b111:  taken = (fu_bus.rs1_data >= fu_bus.rs2_data);                  // BGEU
         default: taken = 1'b0;
      endcase
   end

   always_comb
   begin
      case (br_op_e'(fu_bus.op[1:0]))
         B_COND:  br_pc = taken ? rel_pc : seq_pc;
         B_JAL:   br_pc = rel_pc;
         B_JALR:  br_pc = reg_pc;
         default: br_pc = seq_pc;
      endcase
   end

   // No C extension, so targets must be word aligned
   assign mis = br_pc[1];

endmodule

// File: verilog/exe_alu.sv
// --------------------
// Integer ALU
// Operand X from rs1, pc or zero; operand Y
// from rs2 or the immediate; one cycle
// --------------------
module exe_alu
(
   exe_fu_if.fu            fu_bus,
   output exe_pkg::word_t  rd_data
);
   import exe_pkg::*;

   word_t       x;
   word_t       y;
   logic [4:0]  shamt;

   always_comb
   begin
      case (fu_bus.sel_x)
         X_RS1:   x = fu_bus.rs1_data;
         X_PC:    x = fu_bus.pc;                    // AUIPC style
         default: x = '0;                           // LUI uses zero + imm
      endcase
      y     = (fu_bus.sel_y == Y_IMM) ? fu_bus.imm : fu_bus.rs2_data;
      shamt = y[4:0];                               // RV32 shifts use 5 bits

      case (alu_op_e'(fu_bus.op))
         ADD:     rd_data = x + y;
         SUB:     rd_data = x - y;
         AND:     rd_data = x & y;
         OR:      rd_data = x | y;
         XOR:     rd_data = x ^ y;
         SLL:     rd_data = x << shamt;
         SRL:     rd_data = x >> shamt;
         SRA:     rd_data = word_t'($signed(x) >>> shamt);
         SLT:     rd_data = word_t'($signed(x) < $signed(y));
         SLTU:    rd_data = word_t'(x < y);
         default: rd_data = '0;                     // Unused encodings
      endcase
   end

endmodule

// File: verilog/exe_operand_fwd.sv
// --------------------
// GPR operand forwarding
// Picks rs1/rs2 from MEM, then WB, then the
// register snapshot; x0 is never forwarded
// --------------------
`include "exe_consts.svh"

module exe_operand_fwd
(
   input  exe_pkg::gpr_addr_t                 rs1_addr,
   input  exe_pkg::gpr_addr_t                 rs2_addr,
   input  logic                               rs1_rd,
   input  logic                               rs2_rd,
   input  exe_pkg::word_t [`NUM_GPR-1:0]      gpr,
   input  logic                               fwd_mem_valid,
   input  logic                               fwd_mem_rd_wr,
   input  exe_pkg::gpr_addr_t                 fwd_mem_rd_addr,
   input  exe_pkg::word_t                     fwd_mem_rd_data,
   input  logic                               fwd_wb_valid,
   input  logic                               fwd_wb_rd_wr,
   input  exe_pkg::gpr_addr_t                 fwd_wb_rd_addr,
   input  exe_pkg::word_t                     fwd_wb_rd_data,
   output exe_pkg::word_t                     rs1_data,
   output exe_pkg::word_t                     rs2_data
);
   import exe_pkg::*;

   // Same priority chain for both sources
   function automatic word_t pick(input gpr_addr_t src, input logic src_rd);
      logic nz;
      nz = (src != '0);                                        // x0 stays constant
      if (src_rd & nz & fwd_mem_valid & fwd_mem_rd_wr & (src == fwd_mem_rd_addr))
         pick = fwd_mem_rd_data;                               // Newest value wins
      else if (src_rd & nz & fwd_wb_valid & fwd_wb_rd_wr & (src == fwd_wb_rd_addr))
         pick = fwd_wb_rd_data;
      else
         pick = gpr[src];                                      // Snapshot of the file
   endfunction

   always_comb
   begin
      rs1_data = pick(rs1_addr, rs1_rd);
      rs2_data = pick(rs2_addr, rs2_rd);
   end

endmodule

// File: verilog/exe_fu_if.sv
// --------------------
// Functional unit bus
// Operands and decoded fields from the stage
// core to the ALU, branch and load/store units
// --------------------
interface exe_fu_if;
   import exe_pkg::*;

   word_t        rs1_data;          // Forwarded rs1
   word_t        rs2_data;          // Forwarded rs2
   pc_t          pc;
   word_t        imm;
   logic [2:0]   funct3;            // Branch compare or load/store width
   logic [3:0]   op;                // Unit specific opcode
   sel_x_e       sel_x;
   sel_y_e       sel_y;

   // Core drives everything
   modport core (output rs1_data, rs2_data, pc, imm, funct3, op, sel_x, sel_y);

   // Units only look
   modport fu   (input  rs1_data, rs2_data, pc, imm, funct3, op, sel_x, sel_y);

endinterface

// File: verilog/exe_pkg.sv
// --------------------
// Execute stage package
// Vector types, FSM-free decode enums and the
// result record handed to the memory stage
// --------------------
`include "exe_consts.svh"

package exe_pkg;

   typedef logic [`XLEN-1:0]    word_t;        // Register or ALU data
   typedef logic [`XLEN-1:0]    pc_t;          // Instruction address
   typedef logic [`GPR_ASZ-1:0] gpr_addr_t;    // Register number
   typedef logic [2:0]          ls_size_t;     // Bytes per access: 1, 2 or 4

   // Instruction group from decode
   typedef enum logic [2:0] {
      IG_ALU = 3'd0,
      IG_BR  = 3'd1,
      IG_LD  = 3'd2,
      IG_ST  = 3'd3,
      IG_ILL = 3'd4
   } ig_type_e;

   typedef enum logic [3:0] {
      ADD  = 4'd0,
      SUB  = 4'd1,
      AND  = 4'd2,
      OR   = 4'd3,
      XOR  = 4'd4,
      SLL  = 4'd5,
      SRL  = 4'd6,
      SRA  = 4'd7,
      SLT  = 4'd8,
      SLTU = 4'd9
   } alu_op_e;

   typedef enum logic [1:0] {B_COND = 2'd0, B_JAL = 2'd1, B_JALR = 2'd2} br_op_e;
   typedef enum logic [1:0] {X_RS1 = 2'd0, X_PC = 2'd1, X_ZERO = 2'd2} sel_x_e;
   typedef enum logic       {Y_RS2 = 1'b0, Y_IMM = 1'b1} sel_y_e;

   // --------------------
   // Result record, EXE to MEM
   typedef struct packed {
      pc_t       pc;
      logic      rd_wr;
      gpr_addr_t rd_addr;
      word_t     rd_data;
      logic      is_ld;
      logic      is_st;
      word_t     ls_addr;
      word_t     st_data;
      ls_size_t  size;
      logic      zero_ext;
      logic      instr_err;       // Misaligned target/access or illegal instruction
   } exe_mem_t;

endpackage

// File: include/exe_consts.svh
// --------------------
// Execute stage constants
// Data width, register file size and the
// address masks used for load/store alignment
// --------------------
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// Word and PC width
`define XLEN            32

// General purpose register file
`define NUM_GPR         32
`define GPR_ASZ         5                  // log2 of NUM_GPR

// --------------------
// Alignment masks, a set bit under the mask means misaligned
`define HALF_MIS_MASK   32'h0000_0001      // Halfword must be on an even address
`define WORD_MIS_MASK   32'h0000_0003      // Word needs the low two bits clear

`endif
